//--- common/arcade_macros.svh
/*
 * Constants of the arcade I/O adapter
 * PS/2 set 2 scan codes, joystick bit map and reset stretch length
 */
`ifndef ARCADE_MACROS_SVH
`define ARCADE_MACROS_SVH

// Scan codes, bit 8 set for E0-prefixed keys
`define ARCADE_KEY_M       9'h03A
`define ARCADE_KEY_F1      9'h005
`define ARCADE_KEY_F2      9'h006
`define ARCADE_KEY_A       9'h01C
`define ARCADE_KEY_D       9'h023
`define ARCADE_KEY_F3      9'h004
`define ARCADE_KEY_L       9'h04B
`define ARCADE_KEY_K       9'h042
`define ARCADE_KEY_LEFT    9'h16B
`define ARCADE_KEY_RIGHT   9'h174
`define ARCADE_KEY_CTRL    9'h014
`define ARCADE_KEY_LALT    9'h011
`define ARCADE_KEY_SPACE   9'h029
`define ARCADE_KEY_1       9'h016
`define ARCADE_KEY_2       9'h01E
`define ARCADE_KEY_5       9'h02E
`define ARCADE_KEY_6       9'h036

// Joystick word bit positions
`define ARCADE_JOY_RIGHT   0
`define ARCADE_JOY_LEFT    1
`define ARCADE_JOY_FIRE    4
`define ARCADE_JOY_THRUST  5
`define ARCADE_JOY_SHIELD  6
`define ARCADE_JOY_START   7

`define ARCADE_RST_STRETCH 16   // Game reset hold after all sources clear

`endif

//--- common/arcade_pkg.sv
/*
 * Shared types of the arcade I/O adapter
 * Keyboard event word, cabinet button byte, core and board-side video,
 * stereo audio and HDMI aspect ratio
 */
package arcade_pkg;

	// Host keyboard event, toggle marks a new event
	typedef struct packed {
		logic       toggle;         // Flips on every new event
		logic       pressed;        // 1 = make, 0 = break
		logic [8:0] code;           // Bit 8 is the extended prefix
	} ps2_event_t;

	// Cabinet inputs as the core sees them, all active low
	typedef struct packed {
		logic right_n;
		logic left_n;
		logic one_player_n;
		logic two_players_n;
		logic fire_n;
		logic coin_n;
		logic thrust_n;
		logic shield_n;
	} cab_buttons_t;

	// Raw core video, 3 bits per colour, syncs active high
	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [2:0] b;
		logic       hs;
		logic       vs;
		logic       de;
	} core_video_t;

	// Board video port
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
		logic       hs_n;
		logic       vs_n;
		logic       de;
	} vga_out_t;

	typedef struct packed {
		logic [15:0] left;
		logic [15:0] right;
	} stereo_t;

	typedef struct packed {
		logic [7:0] arx;            // Horizontal part of the ratio
		logic [7:0] ary;            // Vertical part
	} aspect_t;

endpackage

//--- input/key_decoder.sv
/*
 * Keyboard and joystick front end
 * Takes host key events, holds one state bit per cabinet button and
 * merges them with both joysticks into the registered active-low byte
 */
`timescale 1ns/10ps
`include "arcade_macros.svh"

module key_decoder import arcade_pkg::*; (
	input  logic         clk_25,
	input  logic         arst_n,
	input  ps2_event_t   ps2_key,
	input  logic [15:0]  joy_0,
	input  logic [15:0]  joy_1,
	output cab_buttons_t buttons
);

	logic        old_toggle;        // Toggle seen on the last edge
	logic        key_event;
	logic [8:0]  arrow_code;        // Code with the E0 prefix forced
	logic [15:0] joy;               // Both players share the cabinet

	// Held key states, active high
	logic        key_right;
	logic        key_left;
	logic        key_one;
	logic        key_two;
	logic        key_fire;
	logic        key_coin;
	logic        key_thrust;
	logic        key_shield;

	assign key_event  = ps2_key.toggle != old_toggle;
	assign arrow_code = {1'b1, ps2_key.code[7:0]};   // Arrows match with or without prefix
	assign joy        = joy_0 | joy_1;

	////////////////////////////////////////////////////////////////////////////
	// Event detection and key table
	always_ff @(posedge clk_25 or negedge arst_n) begin
		if (!arst_n) begin
			old_toggle <= 1'b0;
			key_right  <= 1'b0;
			key_left   <= 1'b0;
			key_one    <= 1'b0;
			key_two    <= 1'b0;
			key_fire   <= 1'b0;
			key_coin   <= 1'b0;
			key_thrust <= 1'b0;
			key_shield <= 1'b0;
		end else begin
			old_toggle <= ps2_key.toggle;
			if (key_event) begin
				case (ps2_key.code)             // Exact 9-bit match
					`ARCADE_KEY_M, `ARCADE_KEY_CTRL:    key_fire   <= ps2_key.pressed;
					`ARCADE_KEY_F1, `ARCADE_KEY_1:      key_one    <= ps2_key.pressed;
					`ARCADE_KEY_F2, `ARCADE_KEY_2:      key_two    <= ps2_key.pressed;
					`ARCADE_KEY_A:                      key_left   <= ps2_key.pressed;
					`ARCADE_KEY_D:                      key_right  <= ps2_key.pressed;
					`ARCADE_KEY_L, `ARCADE_KEY_LALT:    key_thrust <= ps2_key.pressed;
					`ARCADE_KEY_K, `ARCADE_KEY_SPACE:   key_shield <= ps2_key.pressed;
					`ARCADE_KEY_F3, `ARCADE_KEY_5,
					`ARCADE_KEY_6:                      key_coin   <= ps2_key.pressed;
					default: ;                          // Unmapped key, ignore
				endcase
				// Arrow keys, prefix is don't care
				if (arrow_code == `ARCADE_KEY_LEFT)
					key_left <= ps2_key.pressed;
				if (arrow_code == `ARCADE_KEY_RIGHT)
					key_right <= ps2_key.pressed;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Merge with joysticks, one register stage
	always_ff @(posedge clk_25 or negedge arst_n) begin
		if (!arst_n) begin
			buttons <= '1;                  // Nothing pressed
		end else begin
			buttons.right_n       <= ~(key_right  | joy[`ARCADE_JOY_RIGHT]);
			buttons.left_n        <= ~(key_left   | joy[`ARCADE_JOY_LEFT]);
			buttons.one_player_n  <= ~(key_one    | joy[`ARCADE_JOY_START]);
			buttons.two_players_n <= ~key_two;  // Keyboard only
			buttons.fire_n        <= ~(key_fire   | joy[`ARCADE_JOY_FIRE]);
			buttons.coin_n        <= ~key_coin;   // Keyboard only
			buttons.thrust_n      <= ~(key_thrust | joy[`ARCADE_JOY_THRUST]);
			buttons.shield_n      <= ~(key_shield | joy[`ARCADE_JOY_SHIELD]);
		end
	end

endmodule

//--- logic/reset_ctrl.sv
/*
 * Game reset generator
 * ORs board, OSD, status and download resets, holds the game in reset
 * while any is set and for a fixed stretch after the last one clears
 */
`timescale 1ns/10ps
`include "arcade_macros.svh"

module reset_ctrl (
	input  logic        clk_25,
	input  logic        arst_n,
	input  logic        board_reset,
	input  logic        osd_reset,
	input  logic        rom_download,
	input  logic [31:0] status,
	output logic        game_rst_n
);

	localparam int CNT_W = $clog2(`ARCADE_RST_STRETCH + 1);

	logic             rst_src;      // Any source active
	logic [CNT_W-1:0] cnt;          // Stretch cycles still to go
	logic             rel_n;        // Registered release

	assign rst_src = board_reset | status[0] | osd_reset | rom_download;

	always_ff @(posedge clk_25 or negedge arst_n) begin
		if (!arst_n) begin
			cnt   <= CNT_W'(`ARCADE_RST_STRETCH);
			rel_n <= 1'b0;
		end else if (rst_src) begin
			cnt   <= CNT_W'(`ARCADE_RST_STRETCH);   // Reload while held
			rel_n <= 1'b0;
		end else begin
			if (cnt != '0)
				cnt <= cnt - 1'b1;
			rel_n <= cnt <= CNT_W'(1);   // Last count step releases
		end
	end

	// Asserts at once, releases in step with clk_25
	assign game_rst_n = rel_n & ~rst_src;

endmodule

//--- logic/av_output.sv
/*
 * Video and audio output stage
 * Widens the 3-bit core colour to the 8-bit port, inverts the syncs,
 * doubles the audio byte into stereo and picks the HDMI aspect ratio
 */
`timescale 1ns/10ps

module av_output import arcade_pkg::*; (
	input  logic        clk_25,
	input  logic        arst_n,
	input  core_video_t core_video,
	input  logic [7:0]  core_audio,
	input  logic [31:0] status,
	output vga_out_t    vga,
	output stereo_t     audio,
	output aspect_t     aspect
);

	// Bit replication keeps full black and full white at the ends
	function automatic logic [7:0] widen(input logic [2:0] c);
		return {c, c, c[2:1]};
	endfunction

	logic [15:0] sample;            // Mono sample, both channels get it

	assign sample = {core_audio, core_audio};

	////////////////////////////////////////////////////////////////////////////
	// Video, one cycle latency
	always_ff @(posedge clk_25 or negedge arst_n) begin
		if (!arst_n) begin
			vga.r    <= '0;
			vga.g    <= '0;
			vga.b    <= '0;
			vga.hs_n <= 1'b1;           // Syncs idle high
			vga.vs_n <= 1'b1;
			vga.de   <= 1'b0;
		end else begin
			vga.r    <= widen(core_video.r);
			vga.g    <= widen(core_video.g);
			vga.b    <= widen(core_video.b);
			vga.hs_n <= ~core_video.hs;
			vga.vs_n <= ~core_video.vs;
			vga.de   <= core_video.de;  // Blanking passes as is
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Audio, same latency as video
	always_ff @(posedge clk_25 or negedge arst_n) begin
		if (!arst_n) begin
			audio <= '0;
		end else begin
			audio.left  <= sample;
			audio.right <= sample;
		end
	end

	// Status bit 1 selects wide screen
	always_comb begin
		if (status[1]) begin
			aspect.arx = 8'd16;
			aspect.ary = 8'd9;
		end else begin
			aspect.arx = 8'd4;          // Original cabinet ratio
			aspect.ary = 8'd3;
		end
	end

endmodule

//--- logic/arcade_io.sv
/*
 * Board-side I/O adapter of the tank game core
 * Keyboard and joystick to cabinet buttons, game reset generation and
 * the video, audio and aspect outputs, all in the clk_25 domain
 */
`timescale 1ns/10ps

module arcade_io import arcade_pkg::*; (
	input  logic         clk_25,
	input  logic         arst_n,

	// Host side inputs
	input  ps2_event_t   ps2_key,
	input  logic [15:0]  joy_0,
	input  logic [15:0]  joy_1,
	input  logic         board_reset,
	input  logic         osd_reset,
	input  logic         rom_download,
	input  logic [31:0]  status,    // OSD option word

	// From the game core
	input  core_video_t  core_video,
	input  logic [7:0]   core_audio,

	// To the game core
	output cab_buttons_t buttons,
	output logic         game_rst_n,

	// Board outputs
	output vga_out_t     vga,
	output stereo_t      audio,
	output aspect_t      aspect
);

	////////////////////////////////////////////////////////////////////////////
	// Player inputs
	key_decoder u_keys (
		.clk_25  (clk_25),
		.arst_n  (arst_n),
		.ps2_key (ps2_key),
		.joy_0   (joy_0),
		.joy_1   (joy_1),
		.buttons (buttons)
	);

	////////////////////////////////////////////////////////////////////////////
	// Game reset
	reset_ctrl u_rst (
		.clk_25       (clk_25),
		.arst_n       (arst_n),
		.board_reset  (board_reset),
		.osd_reset    (osd_reset),
		.rom_download (rom_download),
		.status       (status),         // Bit 0 is the OSD reset entry
		.game_rst_n   (game_rst_n)
	);

	////////////////////////////////////////////////////////////////////////////
	// Video and audio
	av_output u_av (
		.clk_25     (clk_25),
		.arst_n     (arst_n),
		.core_video (core_video),
		.core_audio (core_audio),
		.status     (status),           // Bit 1 picks the aspect ratio
		.vga        (vga),
		.audio      (audio),
		.aspect     (aspect)
	);

endmodule

//--- sim/arcade_io_sva.sv
/*
 * Assertions on the arcade I/O adapter
 * Button hold, game reset while a source is set, video de latency
 */
`timescale 1ns/10ps

module arcade_io_sva import arcade_pkg::*; (
	input logic         clk_25,
	input logic         arst_n,
	input ps2_event_t   ps2_key,
	input logic [15:0]  joy_0,
	input logic [15:0]  joy_1,
	input logic         board_reset,
	input logic         osd_reset,
	input logic         rom_download,
	input logic [31:0]  status,
	input core_video_t  core_video,
	input cab_buttons_t buttons,
	input logic         game_rst_n,
	input vga_out_t     vga
);

	// Key path is two edges deep, joystick path one
	assert property (@(posedge clk_25) disable iff (!arst_n)
		$stable(ps2_key.toggle) ##1 ($stable(joy_0) && $stable(joy_1)) |=> $stable(buttons))
		else $error("buttons changed with no key event and no joystick change");

	assert property (@(posedge clk_25)
		(board_reset || osd_reset || rom_download || status[0]) |-> !game_rst_n)
		else $error("game_rst_n high while a reset source is active");

	assert property (@(posedge clk_25) disable iff (!arst_n)
		$past(arst_n) |-> vga.de == $past(core_video.de))
		else $error("vga.de does not follow core de by one cycle");

endmodule

bind arcade_io arcade_io_sva u_sva (.*);

//--- sim/arcade_io_tb.sv
/*
 * Testbench of the arcade I/O adapter
 * Key events, joysticks, reset sources and core video and audio as
 * stimulus, every output compared against a cycle model
 */
`timescale 1ns/10ps
`include "arcade_macros.svh"

module arcade_io_tb import arcade_pkg::*; ();

	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 10;
	localparam int MAX_CYCLES   = 4000;    // About ten times the ~400 cycles of stimulus

	logic         clk_25;
	logic         arst_n;
	ps2_event_t   ps2_key;
	logic [15:0]  joy_0;
	logic [15:0]  joy_1;
	logic         board_reset;
	logic         osd_reset;
	logic         rom_download;
	logic [31:0]  status;
	core_video_t  core_video;
	logic [7:0]   core_audio;
	cab_buttons_t buttons;
	logic         game_rst_n;
	vga_out_t     vga;
	stereo_t      audio;
	aspect_t      aspect;

	// Cycle model state
	logic [7:0]   model_keys;              // Held keys, bit order of cab_buttons_t
	logic         model_toggle;
	int           model_slot;
	int           since_clear;             // Edges since the last reset source cleared
	cab_buttons_t exp_buttons;
	vga_out_t     exp_vga;
	stereo_t      exp_audio;
	int           cycle_count;
	int           error_count;

	logic [8:0] key_codes [17] = '{`ARCADE_KEY_M, `ARCADE_KEY_F1, `ARCADE_KEY_F2,
		`ARCADE_KEY_A, `ARCADE_KEY_D, `ARCADE_KEY_F3, `ARCADE_KEY_L, `ARCADE_KEY_K,
		`ARCADE_KEY_LEFT, `ARCADE_KEY_RIGHT, `ARCADE_KEY_CTRL, `ARCADE_KEY_LALT,
		`ARCADE_KEY_SPACE, `ARCADE_KEY_1, `ARCADE_KEY_2, `ARCADE_KEY_5, `ARCADE_KEY_6};

	arcade_io u_dut (.*);

	initial begin
		clk_25 = 1'b0;
		forever #(CLK_PERIOD / 2) clk_25 = ~clk_25;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference functions

	// Button slot of a scan code, 7 = right down to 0 = shield, -1 unmapped
	function automatic int key_slot(input logic [8:0] code);
		if (code[7:0] == 8'(`ARCADE_KEY_LEFT))
			return 6;                  // Arrows ignore the E0 prefix
		if (code[7:0] == 8'(`ARCADE_KEY_RIGHT))
			return 7;
		case (code)
			`ARCADE_KEY_D:                                return 7;
			`ARCADE_KEY_A:                                return 6;
			`ARCADE_KEY_F1, `ARCADE_KEY_1:                return 5;
			`ARCADE_KEY_F2, `ARCADE_KEY_2:                return 4;
			`ARCADE_KEY_M, `ARCADE_KEY_CTRL:              return 3;
			`ARCADE_KEY_F3, `ARCADE_KEY_5, `ARCADE_KEY_6: return 2;
			`ARCADE_KEY_L, `ARCADE_KEY_LALT:              return 1;
			`ARCADE_KEY_K, `ARCADE_KEY_SPACE:             return 0;
			default:                                      return -1;
		endcase
	endfunction

	function automatic cab_buttons_t expected_buttons(input logic [7:0] keys,
		input logic [15:0] joy);
		logic [7:0] act;
		act = keys;
		act[7] |= joy[`ARCADE_JOY_RIGHT];
		act[6] |= joy[`ARCADE_JOY_LEFT];
		act[5] |= joy[`ARCADE_JOY_START];  // Two players and coin have no joystick bit
		act[3] |= joy[`ARCADE_JOY_FIRE];
		act[1] |= joy[`ARCADE_JOY_THRUST];
		act[0] |= joy[`ARCADE_JOY_SHIELD];
		return cab_buttons_t'(~act);
	endfunction

	function automatic vga_out_t expected_vga(input core_video_t v);
		vga_out_t o;
		o.r    = {v.r, v.r, v.r[2:1]};
		o.g    = {v.g, v.g, v.g[2:1]};
		o.b    = {v.b, v.b, v.b[2:1]};
		o.hs_n = ~v.hs;
		o.vs_n = ~v.vs;
		o.de   = v.de;
		return o;
	endfunction

	function automatic stereo_t expected_audio(input logic [7:0] a);
		return stereo_t'({a, a, a, a});
	endfunction

	function automatic aspect_t expected_aspect(input logic wide);
		return wide ? aspect_t'({8'd16, 8'd9}) : aspect_t'({8'd4, 8'd3});
	endfunction

	function automatic logic expected_reset(input logic active, input int since);
		return !active && since >= `ARCADE_RST_STRETCH;
	endfunction

	function automatic logic source_active();
		return board_reset | osd_reset | rom_download | status[0];
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	task automatic stop_on_error(input string msg);
		error_count++;
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_buttons(input cab_buttons_t got, input cab_buttons_t exp);
		if (got !== exp)
			stop_on_error($sformatf("error at %0t: buttons = %b, expected %b", $time, got, exp));
	endtask

	task automatic check_vga(input vga_out_t got, input vga_out_t exp);
		if (got !== exp)
			stop_on_error($sformatf("error at %0t: vga = %h, expected %h", $time, got, exp));
	endtask

	task automatic check_audio(input stereo_t got, input stereo_t exp);
		if (got !== exp)
			stop_on_error($sformatf("error at %0t: audio = %h, expected %h", $time, got, exp));
	endtask

	task automatic check_aspect(input aspect_t got, input aspect_t exp);
		if (got !== exp)
			stop_on_error($sformatf("error at %0t: aspect = %h, expected %h", $time, got, exp));
	endtask

	task automatic check_reset(input logic got, input logic exp);
		if (got !== exp)
			stop_on_error($sformatf("error at %0t: game_rst_n = %b, expected %b", $time, got, exp));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Cycle model, follows every rising edge
	always @(posedge clk_25 or negedge arst_n) begin
		if (!arst_n) begin
			model_keys   = '0;
			model_toggle = 1'b0;
			since_clear  = 0;
			exp_buttons  = '1;
			exp_vga      = '{r: 8'h00, g: 8'h00, b: 8'h00, hs_n: 1'b1, vs_n: 1'b1, de: 1'b0};
			exp_audio    = '0;
		end else begin
			exp_buttons = expected_buttons(model_keys, joy_0 | joy_1);  // Keys of the last edge
			if (ps2_key.toggle != model_toggle) begin
				model_slot = key_slot(ps2_key.code);
				if (model_slot >= 0)
					model_keys[model_slot] = ps2_key.pressed;
			end
			model_toggle = ps2_key.toggle;
			exp_vga      = expected_vga(core_video);
			exp_audio    = expected_audio(core_audio);
			if (source_active())
				since_clear = 0;
			else if (since_clear < `ARCADE_RST_STRETCH)
				since_clear++;
		end
	end

	// Compare a quarter period after the falling edge, all outputs settled
	initial begin
		forever begin
			@(negedge clk_25);
			#(CLK_PERIOD / 4);
			if (arst_n) begin
				check_buttons(buttons, exp_buttons);
				check_vga(vga, exp_vga);
				check_audio(audio, exp_audio);
				check_aspect(aspect, expected_aspect(status[1]));  // Same cycle
				check_reset(game_rst_n, expected_reset(source_active(), since_clear));
			end
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES) begin
			@(posedge clk_25);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
		$display("Simulation FAILED");
		$fatal(1, "run stopped by the cycle limit");
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus, always on the falling edge
	task automatic send_key(input logic [8:0] code, input logic press);
		@(negedge clk_25);
		ps2_key.toggle  = ~ps2_key.toggle;
		ps2_key.pressed = press;
		ps2_key.code    = code;
		repeat (3) @(negedge clk_25);
	endtask

	task automatic pulse_source(input int which);
		@(negedge clk_25);
		case (which)
			0:       board_reset  = 1'b1;
			1:       osd_reset    = 1'b1;
			2:       rom_download = 1'b1;
			default: status[0]    = 1'b1;
		endcase
		repeat (4) @(negedge clk_25);
		{board_reset, osd_reset, rom_download, status[0]} = '0;
		repeat (`ARCADE_RST_STRETCH + 4) @(negedge clk_25);  // Past the release
	endtask

	initial begin
		int i;
		void'($urandom(32'h09a23c39));
		error_count  = 0;
		arst_n       = 1'b0;
		ps2_key      = '0;
		joy_0        = '0;
		joy_1        = '0;
		board_reset  = 1'b0;
		osd_reset    = 1'b0;
		rom_download = 1'b0;
		status       = '0;
		core_video   = '0;
		core_audio   = '0;
		repeat (RESET_CYCLES / 2) @(negedge clk_25);
		check_buttons(buttons, '1);
		check_vga(vga, '{r: 8'h00, g: 8'h00, b: 8'h00, hs_n: 1'b1, vs_n: 1'b1, de: 1'b0});
		check_reset(game_rst_n, 1'b0);
		repeat (RESET_CYCLES - RESET_CYCLES / 2) @(negedge clk_25);
		arst_n = 1'b1;

		// Make and break of every key, arrows also without the prefix
		for (i = 0; i < 17; i++) begin
			send_key(key_codes[i], 1'b1);
			send_key(key_codes[i], 1'b0);
			if (key_codes[i][8]) begin
				send_key(key_codes[i] & 9'h0FF, 1'b1);
				send_key(key_codes[i] & 9'h0FF, 1'b0);
			end
		end

		// Mapped codes and pressed move without a toggle, no event
		send_key(`ARCADE_KEY_M, 1'b1);
		for (i = 0; i < 8; i++) begin
			@(negedge clk_25);
			ps2_key.code    = key_codes[$urandom % 17];
			ps2_key.pressed = 1'($urandom);
		end
		send_key(`ARCADE_KEY_M, 1'b0);

		// Random joysticks over held keys, random video and audio
		send_key(`ARCADE_KEY_K, 1'b1);
		send_key(`ARCADE_KEY_D, 1'b1);
		for (i = 0; i < 100; i++) begin
			@(negedge clk_25);
			joy_0      = 16'($urandom);
			joy_1      = 16'($urandom);
			core_video = core_video_t'(12'($urandom));
			core_audio = 8'($urandom);
		end
		@(negedge clk_25);
		joy_0 = '0;
		joy_1 = '0;
		send_key(`ARCADE_KEY_K, 1'b0);
		send_key(`ARCADE_KEY_D, 1'b0);

		for (i = 0; i < 4; i++)
			pulse_source(i);

		for (i = 0; i < 8; i++) begin
			@(negedge clk_25);
			status[1] = ~status[1];
		end

		@(negedge clk_25);
		if (error_count == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- build.f
+incdir+common
common/arcade_pkg.sv
input/key_decoder.sv
logic/reset_ctrl.sv
logic/av_output.sv
logic/arcade_io.sv
sim/arcade_io_sva.sv
sim/arcade_io_tb.sv

//--- Bender.yml
package:
  name: arcade_io

export_include_dirs:
  - common

sources:
  - files:
      - common/arcade_pkg.sv
      - input/key_decoder.sv
      - logic/reset_ctrl.sv
      - logic/av_output.sv
      - logic/arcade_io.sv
  - target: simulation
    files:
      - sim/arcade_io_sva.sv
      - sim/arcade_io_tb.sv
